// ==== design/core_params.svh ====
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// datapath
`define DATA_WIDTH 32
`define NUM_REGS 16

// word addressed ram
`define ADDR_WIDTH 8
`define MEM_WORDS 256

// cycles from accepted read to readValid
`define MEM_LATENCY 2

`endif

// ==== design/cpuPkg.sv ====
`default_nettype none

`include "core_params.svh"

package cpuPkg;

    typedef enum logic [3:0] {
        opAdd   = 4'd0,
        opSub   = 4'd1,
        opAnd   = 4'd2,
        opOr    = 4'd3,
        opXor   = 4'd4,
        opAddi  = 4'd5,
        opLoad  = 4'd6,
        opStore = 4'd7,
        opBne   = 4'd8,
        opHalt  = 4'd9     // codes above this run as no-ops
    } opcodes;

    typedef enum logic [2:0] {
        stIdle,
        stFetch,
        stFetchWait,
        stExecute,
        stMemory,
        stMemWait,
        stWriteback,
        stHalted
    } cpuStates;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor
    } aluOps;

    typedef struct packed {
        opcodes             opcode;
        logic        [3:0]  rd;
        logic        [3:0]  ra;
        logic        [3:0]  rb;
        logic signed [15:0] imm;
    } instruction;

    typedef struct packed {
        logic                   read;
        logic                   write;
        logic [`ADDR_WIDTH-1:0] address;
        logic [`DATA_WIDTH-1:0] writeData;
    } busRequest;

    typedef struct packed {
        logic                           writeEnable;
        logic [$clog2(`NUM_REGS)-1:0]   writeSelect;
        logic                           dataSelect;   // 1 selects load data
    } regfileControl;

endpackage

`default_nettype wire

// ==== design/registerFile.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "core_params.svh"

module registerFile(
    input  logic                           clk,
    input  logic                           rstN,
    input  logic [$clog2(`NUM_REGS)-1:0]   readSelectA,
    input  logic [$clog2(`NUM_REGS)-1:0]   readSelectB,
    input  cpuPkg::regfileControl          control,
    input  logic [`DATA_WIDTH-1:0]         writeData,
    output logic [`DATA_WIDTH-1:0]         readDataA,
    output logic [`DATA_WIDTH-1:0]         readDataB
);

    logic [`DATA_WIDTH-1:0] regs [`NUM_REGS];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (control.writeEnable && control.writeSelect != '0) begin
            regs[control.writeSelect] <= writeData;   // r0 never written
        end
    end

    // combinational reads, r0 forced to zero
    assign readDataA = (readSelectA == '0) ? '0 : regs[readSelectA];
    assign readDataB = (readSelectB == '0) ? '0 : regs[readSelectB];

endmodule

`default_nettype wire

// ==== design/execute.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "core_params.svh"

module execute(
    input  cpuPkg::aluOps           aluOp,
    input  logic [`DATA_WIDTH-1:0]  operandA,
    input  logic [`DATA_WIDTH-1:0]  operandB,
    output logic [`DATA_WIDTH-1:0]  result,
    output logic                    zero
);

    import cpuPkg::*;

    logic                   subtract;
    logic [`DATA_WIDTH-1:0] addend;
    logic [`DATA_WIDTH-1:0] sum;

    // one adder for add, addi, address and bne compare
    assign subtract = (aluOp == aluSub);
    assign addend   = subtract ? ~operandB : operandB;
    assign sum      = operandA + addend + {{(`DATA_WIDTH-1){1'b0}}, subtract};

    always_comb begin
        case (aluOp)
            aluAdd,
            aluSub:  result = sum;
            aluAnd:  result = operandA & operandB;
            aluOr:   result = operandA | operandB;
            aluXor:  result = operandA ^ operandB;
            default: result = sum;
        endcase
    end

    assign zero = (result == '0);   // equal operands on sub

endmodule

`default_nettype wire

// ==== design/controller.sv ====
`timescale 1ns/10ps
`default_nettype none

module controller(
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    start,
    input  cpuPkg::opcodes          opcode,
    input  logic                    zero,
    input  logic                    waitRequest,
    input  logic                    readValid,
    output cpuPkg::aluOps           aluOp,
    output logic                    useImmediate,
    output logic                    pcLoad,
    output logic                    pcBranch,
    output logic                    irLoad,
    output cpuPkg::regfileControl   regControl,
    output logic                    busRead,
    output logic                    busWrite,
    output logic                    addressSelect,
    output logic                    halted
);

    import cpuPkg::*;

    cpuStates state;
    cpuStates nextState;
    logic     writesRegister;
    logic     memoryAccess;

    assign memoryAccess   = (opcode == opLoad) || (opcode == opStore);
    assign writesRegister = (opcode inside {opAdd, opSub, opAnd, opOr, opXor, opAddi, opLoad});

    always_ff @(posedge clk) begin
        if (!rstN)
            state <= stIdle;
        else
            state <= nextState;
    end

    always_comb begin
        nextState = state;
        case (state)
            stIdle: begin
                if (start)
                    nextState = stFetch;
            end
            stFetch: begin
                if (!waitRequest)
                    nextState = stFetchWait;
            end
            stFetchWait: begin
                if (readValid)
                    nextState = stExecute;
            end
            stExecute: begin
                if (opcode == opHalt)
                    nextState = stHalted;
                else if (memoryAccess)
                    nextState = stMemory;
                else
                    nextState = stWriteback;
            end
            stMemory: begin
                if (!waitRequest)
                    nextState = (opcode == opLoad) ? stMemWait : stWriteback;
            end
            stMemWait: begin
                if (readValid)
                    nextState = stWriteback;
            end
            stWriteback: nextState = stFetch;
            stHalted:    nextState = stHalted;   // only reset leaves
            default:     nextState = stIdle;
        endcase
    end

    // alu decode depends on opcode only
    always_comb begin
        case (opcode)
            opSub,
            opBne:   aluOp = aluSub;
            opAnd:   aluOp = aluAnd;
            opOr:    aluOp = aluOr;
            opXor:   aluOp = aluXor;
            default: aluOp = aluAdd;
        endcase
    end

    assign useImmediate = (opcode == opAddi) || memoryAccess;

    assign irLoad   = (state == stFetchWait) && readValid;
    assign pcLoad   = (state == stWriteback);
    assign pcBranch = (state == stWriteback) && (opcode == opBne) && !zero;

    assign regControl.writeEnable = (state == stWriteback) && writesRegister;
    assign regControl.writeSelect = '0;     // core fills in rd
    assign regControl.dataSelect  = (opcode == opLoad);

    assign busRead  = (state == stFetch) || ((state == stMemory) && (opcode == opLoad));
    assign busWrite = (state == stMemory) && (opcode == opStore);
    assign addressSelect = (state == stMemory);     // alu result as address

    assign halted = (state == stHalted);

endmodule

`default_nettype wire

// ==== design/cpu32e.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "core_params.svh"

module cpu32e(
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    start,
    input  logic                    waitRequest,
    input  logic                    readValid,
    input  logic [`DATA_WIDTH-1:0]  readData,
    output cpuPkg::busRequest       bus,
    output logic                    halted
);

    import cpuPkg::*;

    // control lines
    aluOps          aluOp;
    regfileControl  regControl;
    regfileControl  fileControl;
    logic           useImmediate;
    logic           pcLoad;
    logic           pcBranch;
    logic           irLoad;
    logic           busRead;
    logic           busWrite;
    logic           addressSelect;
    logic           zero;

    // datapath
    instruction             ir;
    logic [`ADDR_WIDTH-1:0] pc;
    logic [`DATA_WIDTH-1:0] dataReg;
    logic [`DATA_WIDTH-1:0] immExtended;
    logic [`DATA_WIDTH-1:0] readDataA;
    logic [`DATA_WIDTH-1:0] readDataB;
    logic [`DATA_WIDTH-1:0] operandB;
    logic [`DATA_WIDTH-1:0] aluResult;
    logic [`DATA_WIDTH-1:0] writeData;

    assign immExtended = {{(`DATA_WIDTH-16){ir.imm[15]}}, ir.imm};
    assign operandB    = useImmediate ? immExtended : readDataB;
    assign writeData   = fileControl.dataSelect ? dataReg : aluResult;

    // destination register comes from the ir
    assign fileControl = '{writeEnable: regControl.writeEnable,
                           writeSelect: ir.rd,
                           dataSelect:  regControl.dataSelect};

    always_ff @(posedge clk) begin
        if (!rstN)
            pc <= '0;
        else if (pcLoad)
            pc <= pc + `ADDR_WIDTH'(1) + (pcBranch ? immExtended[`ADDR_WIDTH-1:0] : '0);
    end

    always_ff @(posedge clk) begin
        if (irLoad)
            ir <= instruction'(readData);
        if (readValid)
            dataReg <= readData;    // load data held for writeback
    end

    assign bus.read      = busRead;
    assign bus.write     = busWrite;
    assign bus.address   = addressSelect ? aluResult[`ADDR_WIDTH-1:0] : pc;
    assign bus.writeData = readDataB;   // store source is rb

    controller controller(
        .clk, .rstN, .start,
        .opcode (ir.opcode),
        .zero, .waitRequest, .readValid,
        .aluOp, .useImmediate, .pcLoad, .pcBranch, .irLoad, .regControl,
        .busRead, .busWrite, .addressSelect, .halted
    );

    registerFile registerFile(
        .clk, .rstN,
        .readSelectA (ir.ra),
        .readSelectB (ir.rb),
        .control     (fileControl),
        .writeData, .readDataA, .readDataB
    );

    execute execute(
        .aluOp,
        .operandA (readDataA),
        .operandB,
        .result   (aluResult),
        .zero
    );

endmodule

`default_nettype wire

// ==== design/busArbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

module busArbiter(
    input  logic                clk,
    input  logic                rstN,
    input  cpuPkg::busRequest   hostRequest,
    input  cpuPkg::busRequest   cpuRequest,
    output logic                hostWait,
    output logic                cpuWait,
    output logic                hostValid,
    output logic                cpuValid,
    output cpuPkg::busRequest   memRequest,
    input  logic                memWait,
    input  logic                memValid
);

    logic hostActive;
    logic readPending;
    logic ownerHost;    // owner of the outstanding read
    logic readAccepted;

    assign hostActive = hostRequest.read | hostRequest.write;

    // host wins a tie, nothing passes while a read is out
    always_comb begin
        if (readPending)
            memRequest = '0;
        else if (hostActive)
            memRequest = hostRequest;
        else
            memRequest = cpuRequest;
    end

    assign readAccepted = !readPending && memRequest.read && !memWait;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            readPending <= 1'b0;
            ownerHost   <= 1'b0;
        end else if (readAccepted) begin
            readPending <= 1'b1;
            ownerHost   <= hostActive;
        end else if (memValid) begin
            readPending <= 1'b0;
        end
    end

    assign hostWait = readPending | memWait;
    assign cpuWait  = readPending | hostActive | memWait;

    // read data steered to its owner only
    assign hostValid = memValid & readPending & ownerHost;
    assign cpuValid  = memValid & readPending & ~ownerHost;

endmodule

`default_nettype wire

// ==== design/memory.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "core_params.svh"

module memory(
    input  logic                    clk,
    input  logic                    rstN,
    input  cpuPkg::busRequest       request,
    output logic                    waitRequest,
    output logic                    readValid,
    output logic [`DATA_WIDTH-1:0]  readData
);

    logic [`DATA_WIDTH-1:0]  ram [`MEM_WORDS];
    logic [`MEM_LATENCY-1:0] validPipe;
    logic                    accept;

    // one read in flight at a time
    assign waitRequest = |validPipe;
    assign accept      = (request.read | request.write) & ~waitRequest;
    assign readValid   = validPipe[`MEM_LATENCY-1];

    always_ff @(posedge clk) begin
        if (!rstN)
            validPipe <= '0;
        else
            validPipe <= {validPipe[`MEM_LATENCY-2:0], accept & request.read};
    end

    always_ff @(posedge clk) begin
        if (accept && request.write)
            ram[request.address] <= request.writeData;
        if (accept && request.read)
            readData <= ram[request.address];   // stable until readValid
    end

endmodule

`default_nettype wire

// ==== design/soc32e.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "core_params.svh"

module soc32e(
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    start,
    input  cpuPkg::busRequest       hostRequest,
    output logic                    hostWait,
    output logic                    hostValid,
    output logic [`DATA_WIDTH-1:0]  readData,
    output logic                    halted
);

    import cpuPkg::*;

    busRequest  cpuRequest;
    busRequest  memRequest;
    logic       cpuWait;
    logic       cpuValid;
    logic       memWait;
    logic       memValid;

    cpu32e cpu32e(
        .clk, .rstN, .start,
        .waitRequest (cpuWait),
        .readValid   (cpuValid),
        .readData,
        .bus         (cpuRequest),
        .halted
    );

    busArbiter busArbiter(
        .clk, .rstN,
        .hostRequest, .cpuRequest,
        .hostWait, .cpuWait, .hostValid, .cpuValid,
        .memRequest, .memWait, .memValid
    );

    // read data shared, valid is steered
    memory memory(
        .clk, .rstN,
        .request     (memRequest),
        .waitRequest (memWait),
        .readValid   (memValid),
        .readData
    );

endmodule

`default_nettype wire

// ==== sim/programs.svh ====
`ifndef PROGRAMS_SVH
`define PROGRAMS_SVH

localparam int progLength = 20;
localparam int progCount  = 3;

// instruction words {opcode, rd, ra, rb, imm16}, one row per program
localparam logic [31:0] programs [progCount][progLength] = '{
    // all alu opcodes and addi on operands from 0x80/0x81, r0 written then stored
    '{32'h51000080, 32'h62100000, 32'h63100001, 32'h04230000,
      32'h15230000, 32'h26230000, 32'h37230000, 32'h48230000,
      32'h5920FFFB, 32'h00230000, 32'h70140002, 32'h70150003,
      32'h70160004, 32'h70170005, 32'h70180006, 32'h70190007,
      32'h70100008, 32'h90000000, 32'h90000000, 32'h90000000},
    // load/store around base 0x88 with signed offsets
    '{32'h51000088, 32'h6210FFF8, 32'h6310FFFB, 32'h64100003,
      32'h70120004, 32'h7013FFFF, 32'h70140007, 32'h5510FFFA,
      32'h66500000, 32'h70560008, 32'h90000000, 32'h90000000,
      32'h90000000, 32'h90000000, 32'h90000000, 32'h90000000,
      32'h90000000, 32'h90000000, 32'h90000000, 32'h90000000},
    // bne loop of five, bne not taken, bne taken over a store, unused opcode
    '{32'h51000080, 32'h52000005, 32'h53300001, 32'h04430000,
      32'h8032FFFD, 32'h80320002, 32'h70130009, 32'h7014000A,
      32'h80200001, 32'h7012000B, 32'hA5000007, 32'h7015000C,
      32'h90000000, 32'h90000000, 32'h90000000, 32'h90000000,
      32'h90000000, 32'h90000000, 32'h90000000, 32'h90000000}
};

// instructions to halt, with margin
localparam int stepBound [progCount] = '{24, 16, 32};

`endif

// ==== sim/socTb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "core_params.svh"

module socTb;

    import cpuPkg::*;

    `include "programs.svh"

    localparam int windowBase = 'h80;   // program data words
    localparam int windowSize = 16;
    localparam int hostBase   = 'hC0;   // words only the host touches
    localparam int stepTotal  = 2 * stepBound[0] + stepBound[1] + 2 * stepBound[2];
    localparam int hostAccessBound = 300;   // all host reads and writes, with slack
    localparam int watchdogCycles  = (stepTotal + hostAccessBound) * 20;

    logic                   clk = 1'b0;
    logic                   rstN;
    logic                   start;
    busRequest              hostReq;
    logic                   hostWait;
    logic                   hostValid;
    logic [`DATA_WIDTH-1:0] readData;
    logic                   halted;

    logic [`DATA_WIDTH-1:0] modelMem [`MEM_WORDS];
    integer                 seed;
    int                     checks = 0;
    int                     errors = 0;
    int                     haltErrors = 0;
    logic                   haltSeen = 1'b0;

    soc32e u_dut(
        .clk, .rstN, .start,
        .hostRequest (hostReq),
        .hostWait, .hostValid, .readData, .halted
    );

    always #5 clk = ~clk;

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        checks = checks + 1;
        if (actual !== expected) begin
            errors = errors + 1;
            $display("FAILED %s: got %h expected %h", name, actual, expected);
        end
    endtask

    // ISA model on modelMem, returns instructions run or -1 past the bound
    function automatic int executeProgram(input int prog);
        logic [31:0] regs [`NUM_REGS];
        logic [31:0] word;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] result;
        logic [3:0]  rd;
        logic [7:0]  pc;
        logic [7:0]  address;
        logic        writeBack;
        logic        done;
        int          steps;
        for (int i = 0; i < `NUM_REGS; i++)
            regs[i] = '0;
        pc = '0;
        steps = 0;
        done = 1'b0;
        while (!done && steps < stepBound[prog]) begin
            steps = steps + 1;
            word = modelMem[pc];
            rd = word[27:24];
            a = regs[word[23:20]];
            b = regs[word[19:16]];
            imm = {{16{word[15]}}, word[15:0]};
            address = a[7:0] + imm[7:0];
            result = '0;
            writeBack = 1'b1;
            pc = pc + 8'd1;
            case (word[31:28])
                4'd0: result = a + b;
                4'd1: result = a - b;
                4'd2: result = a & b;
                4'd3: result = a | b;
                4'd4: result = a ^ b;
                4'd5: result = a + imm;
                4'd6: result = modelMem[address];
                4'd7: begin
                    modelMem[address] = b;
                    writeBack = 1'b0;
                end
                4'd8: begin
                    if (a != b)
                        pc = pc + imm[7:0];   // relative to the next word
                    writeBack = 1'b0;
                end
                4'd9: begin
                    done = 1'b1;
                    writeBack = 1'b0;
                end
                default: writeBack = 1'b0;    // unused codes
            endcase
            if (writeBack && rd != 4'd0)
                regs[rd] = result;
        end
        return done ? steps : -1;
    endfunction

    task automatic resetDut();
        rstN = 1'b0;
        start = 1'b0;
        hostReq = '0;
        repeat (2) @(negedge clk);
        rstN = 1'b1;
        checkValue("halted", {31'b0, halted}, 32'h0);
    endtask

    // all bus tasks start and end on a falling edge
    task automatic hostWrite(input logic [7:0] address, input logic [31:0] data);
        hostReq = '0;
        hostReq.write = 1'b1;
        hostReq.address = address;
        hostReq.writeData = data;
        while (hostWait)
            @(negedge clk);
        @(negedge clk);     // taken on the rising edge just passed
        hostReq = '0;
    endtask

    task automatic hostRead(input logic [7:0] address, output logic [31:0] data);
        hostReq = '0;
        hostReq.read = 1'b1;
        hostReq.address = address;
        while (hostWait)
            @(negedge clk);
        @(negedge clk);
        hostReq = '0;
        while (!hostValid)
            @(negedge clk);
        data = readData;
        @(negedge clk);
        checkValue("hostValid", {31'b0, hostValid}, 32'h0);   // single pulse
    endtask

    task automatic loadImage(input int prog);
        logic [31:0] data;
        for (int i = 0; i < progLength; i++) begin
            hostWrite(8'(i), programs[prog][i]);
            modelMem[i] = programs[prog][i];
        end
        for (int i = 0; i < windowSize; i++) begin
            data = $random(seed);
            hostWrite(8'(windowBase + i), data);
            modelMem[windowBase + i] = data;
        end
    endtask

    task automatic compareWords(input int first, input int count);
        logic [31:0] data;
        for (int i = first; i < first + count; i++) begin
            hostRead(8'(i), data);
            checkValue($sformatf("mem[%h]", 8'(i)), data, modelMem[i]);
        end
    endtask

    task automatic runProgram(input int prog, input bit withHostReads);
        logic [31:0] data;
        int          steps;
        int          reads;
        steps = executeProgram(prog);
        reads = 0;
        if (steps < 0) begin
            errors = errors + 1;
            $display("reference model of program %0d did not reach halt", prog);
        end
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        while (!halted) begin
            if (withHostReads) begin
                hostRead(8'(hostBase + reads % windowSize), data);
                checkValue($sformatf("mem[%h]", 8'(hostBase + reads % windowSize)),
                           data, modelMem[hostBase + reads % windowSize]);
                reads = reads + 1;
                @(negedge clk);     // one idle cycle so the core gets the bus
            end else begin
                @(negedge clk);
            end
        end
        if (withHostReads && reads == 0) begin
            errors = errors + 1;
            $display("no host read overlapped the run of program %0d", prog);
        end
        compareWords(windowBase, windowSize);
    endtask

    // once up, halted holds until reset
    always @(negedge clk) begin
        if (!rstN) begin
            haltSeen = 1'b0;
        end else begin
            if (haltSeen && !halted) begin
                haltErrors = haltErrors + 1;
                $display("halted dropped while out of reset");
            end
            if (halted)
                haltSeen = 1'b1;
        end
    end

    initial begin
        repeat (watchdogCycles) @(posedge clk);
        $display("watchdog expired after %0d cycles", watchdogCycles);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        logic [31:0] data;
        int          total;
        seed = 32'he2875c0d;
        resetDut();

        for (int i = 0; i < windowSize; i++) begin
            data = $random(seed);
            hostWrite(8'(hostBase + i), data);
            modelMem[hostBase + i] = data;
        end
        compareWords(hostBase, windowSize);

        // core stays idle without start, long enough for a stray run to halt
        loadImage(0);
        repeat (stepBound[0] * 20) @(negedge clk);
        checkValue("halted", {31'b0, halted}, 32'h0);
        compareWords(0, progLength);
        compareWords(windowBase, windowSize);
        runProgram(0, 1'b0);

        resetDut();
        loadImage(1);
        runProgram(1, 1'b0);

        resetDut();
        loadImage(2);
        runProgram(2, 1'b0);

        // same loop with host reads competing for the bus
        resetDut();
        loadImage(2);
        runProgram(2, 1'b1);

        total = errors + haltErrors;
        $display("checks %0d, errors %0d", checks, total);
        if (total == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+design
+incdir+sim
design/cpuPkg.sv
design/registerFile.sv
design/execute.sv
design/controller.sv
design/cpu32e.sv
design/busArbiter.sv
design/memory.sv
design/soc32e.sv
sim/socTb.sv

// ==== run.sh ====
#!/bin/sh
# build with verilator, run, and judge the result from the log
set -e
cd "$(dirname "$0")"

verilator --binary --top-module socTb -Mdir obj_dir -f list.f
./obj_dir/VsocTb | tee sim.log

if grep -qx "STATUS: PASS" sim.log; then
    exit 0
fi
echo "simulation did not pass, see sim.log"
exit 1
